// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_cpu_system
RTL_TOP    ?= cpu_system
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/cpu_alu.sv
rtl/cpu_ram.sv
rtl/apb_host_port.sv
rtl/cpu_core.sv
rtl/cpu_system.sv
sim/tb_cpu_system.sv

// ==== rtl/apb_host_port.sv ====
`timescale 1ns/1ps

module apb_host_port import cpu_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              run,
  input  logic [DATA_W-1:0] acc,
  input  logic [DATA_W-1:0] status,
  input  logic              halted,
  output logic [ADDR_W-1:0] ram_addr,
  output logic [DATA_W-1:0] ram_wdata,
  output logic              ram_we,
  input  logic [DATA_W-1:0] ram_rdata
);

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  logic access;
  logic ram_sel;
  logic ctrl_sel;
  logic stat_sel;
  logic bad_addr;

  // Access phase of an APB transfer
  assign access   = psel & penable;
  // Bit 16 clear is RAM
  assign ram_sel  = (paddr[APB_AW-1] == APB_RAM_BASE[APB_AW-1]);
  // Registers decoded on word boundaries
  assign ctrl_sel = (paddr[APB_AW-1:2] == APB_CTRL_ADDR[APB_AW-1:2]);
  assign stat_sel = (paddr[APB_AW-1:2] == APB_STAT_ADDR[APB_AW-1:2]);
  assign bad_addr = !ram_sel && !ctrl_sel && !stat_sel;

  // RAM host port
  assign ram_addr  = paddr[ADDR_W-1:0];
  assign ram_wdata = pwdata[DATA_W-1:0];
  assign ram_we    = access && pwrite && ram_sel;

  // Run control
  always_ff @(posedge clk) begin
    if (!resetn) begin
      run <= 1'b0;
    end else if (access && pwrite && ctrl_sel) begin
      run <= pwdata[0];
    end
  end

  // Read mux, STAT is halted, A, P from the top down
  always_comb begin
    prdata = '0;
    if (ram_sel) begin
      prdata[DATA_W-1:0] = ram_rdata;
    end else if (ctrl_sel) begin
      prdata[0] = run;
    end else if (stat_sel) begin
      prdata[2*DATA_W:0] = {halted, acc, status};
    end
  end

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && (bad_addr || (stat_sel && pwrite));

endmodule

// ==== rtl/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  alu_op_t           op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic              cin,
  output logic [DATA_W-1:0] y,
  output logic [DATA_W-1:0] flags
);

  // Sum with room for the carry out
  logic [DATA_W:0] sum;
  logic            carry;
  logic            ovf;

  // ----------------------------------------------------------
  // Result
  // ----------------------------------------------------------
  always_comb begin
    sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, cin};
    carry = 1'b0;
    ovf = 1'b0;
    case (op)
      ALU_ADD: begin
        y = sum[DATA_W-1:0];
        carry = sum[DATA_W];
        // Signed overflow when like signs give an unlike sign
        ovf = (a[DATA_W-1] == b[DATA_W-1]) && (y[DATA_W-1] != a[DATA_W-1]);
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_SL: begin
        // Old bit 7 goes to carry
        y = {a[DATA_W-2:0], 1'b0};
        carry = a[DATA_W-1];
      end
      ALU_PASS: begin
        y = b;
      end
      default: begin
        y = b;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Flags at their P positions
  // ----------------------------------------------------------
  always_comb begin
    flags = '0;
    flags[FLAG_N] = y[DATA_W-1];
    flags[FLAG_Z] = (y == '0);
    flags[FLAG_V] = ovf;
    flags[FLAG_C] = carry;
  end

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic              run,
  mem_bus_if.core           mem,
  output alu_op_t           alu_op,
  output logic [DATA_W-1:0] alu_a,
  output logic [DATA_W-1:0] alu_b,
  output logic              alu_cin,
  input  logic [DATA_W-1:0] alu_y,
  input  logic [DATA_W-1:0] alu_flags,
  output logic [DATA_W-1:0] acc,
  output logic [DATA_W-1:0] status,
  output logic              halted
);

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  // Accumulator and processor status
  logic [DATA_W-1:0] a_reg;
  logic [DATA_W-1:0] p_reg;
  logic [ADDR_W-1:0] pc;
  opcode_u           ir;

  // Low operand byte, held until the high byte arrives
  logic [DATA_W-1:0] op_lo;

  // Pending writeback at the next FETCH
  logic upd_acc;
  logic upd_flags;

  logic [NUM_STATES-1:0] state;
  logic [NUM_STATES-1:0] next;

  // Status word with the ALU flags merged in
  logic [DATA_W-1:0] p_next;

  // Decode results
  logic    is_nop;
  logic    is_jmp;
  logic    is_asl;
  logic    is_grp1;
  logic    is_sta;
  alu_op_t grp1_op;

  // ----------------------------------------------------------
  // Instruction decode
  // ----------------------------------------------------------
  always_comb begin
    // Odd ones out compared as full bytes
    is_nop = (ir.raw == NOP);
    is_jmp = (ir.raw == JMP_ABS);
    is_asl = (ir.raw == ASL_ABS);
    // Group one in absolute mode, only four of the eight ops
    is_grp1 = (ir.f.cc == CC_GRP1) && (ir.f.bbb == MODE_ABS) &&
              (ir.f.aaa inside {AAA_ADC, AAA_AND, AAA_LDA, AAA_STA});
    is_sta = is_grp1 && (ir.f.aaa == AAA_STA);
    // ALU operation straight from aaa
    case (ir.f.aaa)
      AAA_ADC: grp1_op = ALU_ADD;
      AAA_AND: grp1_op = ALU_AND;
      default: grp1_op = ALU_PASS;
    endcase
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    next = '0;
    case (1'b1)
      state[S_RESET]:    next[S_VECTOR_1] = 1'b1;
      state[S_VECTOR_1]: next[S_VECTOR_2] = 1'b1;
      state[S_VECTOR_2]: next[S_FETCH] = 1'b1;
      state[S_FETCH]:    next[S_DECODE] = 1'b1;
      state[S_DECODE]: begin
        if (is_nop) begin
          next[S_FETCH] = 1'b1;
        end else if (is_jmp || is_asl || is_grp1) begin
          next[S_ABS_1] = 1'b1;
        end else begin
          // BRK and everything unknown
          next[S_HALT] = 1'b1;
        end
      end
      state[S_ABS_1]: begin
        // JMP done in three cycles
        if (is_jmp) begin
          next[S_FETCH] = 1'b1;
        end else begin
          next[S_ABS_2] = 1'b1;
        end
      end
      state[S_ABS_2]: begin
        // Read-modify-write needs two more
        if (is_asl) begin
          next[S_ABS_3] = 1'b1;
        end else begin
          next[S_FETCH] = 1'b1;
        end
      end
      state[S_ABS_3]: next[S_ABS_4] = 1'b1;
      state[S_ABS_4]: next[S_FETCH] = 1'b1;
      state[S_HALT]:  next[S_HALT] = 1'b1;
      default:        next[S_RESET] = 1'b1;
    endcase
  end

  // Flags merged per operation that produced them
  always_comb begin
    p_next = p_reg;
    if (upd_flags) begin
      p_next[FLAG_N] = alu_flags[FLAG_N];
      p_next[FLAG_Z] = alu_flags[FLAG_Z];
      if (alu_op == ALU_ADD) begin
        p_next[FLAG_V] = alu_flags[FLAG_V];
      end
      if (alu_op == ALU_ADD || alu_op == ALU_SL) begin
        p_next[FLAG_C] = alu_flags[FLAG_C];
      end
    end
  end

  // ----------------------------------------------------------
  // Instruction cycle
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    // Stopped core sits in RESET
    if (!resetn || !run) begin
      state <= '0;
      state[S_RESET] <= 1'b1;
      mem.addr <= RESET_VEC_LO;
      mem.wr_en <= 1'b0;
      a_reg <= '0;
      p_reg <= '0;
      p_reg[FLAG_UNUSED] <= 1'b1;
      upd_acc <= 1'b0;
      upd_flags <= 1'b0;
    end else begin
      state <= next;
      case (1'b1)
        state[S_VECTOR_1]: begin
          pc[DATA_W-1:0] <= mem.rd_data;
          mem.addr <= RESET_VEC_HI;
        end
        state[S_VECTOR_2]: begin
          pc[ADDR_W-1:DATA_W] <= mem.rd_data;
          mem.addr <= {mem.rd_data, pc[DATA_W-1:0]};
        end
        state[S_FETCH]: begin
          ir.raw <= mem.rd_data;
          mem.addr <= pc + 16'd1;
          // Retire the previous ALU result
          p_reg <= p_next;
          if (upd_acc) begin
            a_reg <= alu_y;
          end
          upd_acc <= 1'b0;
          upd_flags <= 1'b0;
        end
        state[S_DECODE]: begin
          op_lo <= mem.rd_data;
          if (is_nop) begin
            pc <= pc + 16'd1;
            mem.addr <= pc + 16'd1;
          end else begin
            mem.addr <= pc + 16'd2;
          end
        end
        state[S_ABS_1]: begin
          // Operand address now complete
          mem.addr <= {mem.rd_data, op_lo};
          if (is_jmp) begin
            pc <= {mem.rd_data, op_lo};
          end
          // STA writes at the end of ABS_2
          if (is_sta) begin
            mem.wr_data <= a_reg;
            mem.wr_en <= 1'b1;
          end
        end
        state[S_ABS_2]: begin
          alu_cin <= p_reg[FLAG_C];
          if (is_asl) begin
            // Shift the memory byte, address stays put
            alu_op <= ALU_SL;
            alu_a <= mem.rd_data;
            alu_b <= mem.rd_data;
            upd_flags <= 1'b1;
          end else begin
            pc <= pc + 16'd3;
            mem.addr <= pc + 16'd3;
            mem.wr_en <= 1'b0;
            if (!is_sta) begin
              alu_op <= grp1_op;
              alu_a <= a_reg;
              alu_b <= mem.rd_data;
              upd_acc <= 1'b1;
              upd_flags <= 1'b1;
            end
          end
        end
        state[S_ABS_3]: begin
          // Shifted byte back to the same address
          mem.wr_data <= alu_y;
          mem.wr_en <= 1'b1;
        end
        state[S_ABS_4]: begin
          mem.wr_en <= 1'b0;
          pc <= pc + 16'd3;
          mem.addr <= pc + 16'd3;
        end
        default: begin
        end
      endcase
    end
  end

  assign acc    = a_reg;
  assign status = p_reg;
  assign halted = state[S_HALT];

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  // ----------------------------------------------------------
  // Data path widths
  // ----------------------------------------------------------
  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  // Host bus widths
  localparam int APB_AW = 17;
  localparam int APB_DW = 32;

  // ----------------------------------------------------------
  // Opcodes
  // ----------------------------------------------------------
  localparam logic [7:0] ADC_ABS = 8'h6D;
  localparam logic [7:0] AND_ABS = 8'h2D;
  localparam logic [7:0] ASL_ABS = 8'h0E;
  localparam logic [7:0] LDA_ABS = 8'hAD;
  localparam logic [7:0] STA_ABS = 8'h8D;
  localparam logic [7:0] JMP_ABS = 8'h4C;
  localparam logic [7:0] NOP     = 8'hEA;

  // Opcode fields for group one instructions
  localparam logic [2:0] MODE_ABS = 3'b011;
  localparam logic [1:0] CC_GRP1  = ADC_ABS[1:0];
  localparam logic [2:0] AAA_ADC  = ADC_ABS[7:5];
  localparam logic [2:0] AAA_AND  = AND_ABS[7:5];
  localparam logic [2:0] AAA_LDA  = LDA_ABS[7:5];
  localparam logic [2:0] AAA_STA  = STA_ABS[7:5];

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_AND  = 3'd1,
    ALU_SL   = 3'd2,
    ALU_PASS = 3'd3
  } alu_op_t;

  // Bit positions in P
  localparam int FLAG_C      = 0;
  localparam int FLAG_Z      = 1;
  localparam int FLAG_UNUSED = 5;
  localparam int FLAG_V      = 6;
  localparam int FLAG_N      = 7;

  // Reset vector location
  localparam logic [ADDR_W-1:0] RESET_VEC_LO = 16'hFFFC;
  localparam logic [ADDR_W-1:0] RESET_VEC_HI = 16'hFFFD;

  // ----------------------------------------------------------
  // Host address map
  // ----------------------------------------------------------
  localparam logic [APB_AW-1:0] APB_RAM_BASE  = 17'h0_0000;
  localparam logic [APB_AW-1:0] APB_CTRL_ADDR = 17'h1_0000;
  localparam logic [APB_AW-1:0] APB_STAT_ADDR = 17'h1_0004;

  // One-hot state indices of the core
  localparam int S_RESET    = 0;
  localparam int S_VECTOR_1 = 1;
  localparam int S_VECTOR_2 = 2;
  localparam int S_FETCH    = 3;
  localparam int S_DECODE   = 4;
  localparam int S_ABS_1    = 5;
  localparam int S_ABS_2    = 6;
  localparam int S_ABS_3    = 7;
  localparam int S_ABS_4    = 8;
  localparam int S_HALT     = 9;
  localparam int NUM_STATES = 10;

  // 6502 opcode layout aaabbbcc
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
  } opcode_fields_t;

  // Same byte seen whole or split into fields
  typedef union packed {
    logic [7:0]     raw;
    opcode_fields_t f;
  } opcode_u;

endpackage

// ==== rtl/cpu_ram.sv ====
`timescale 1ns/1ps

module cpu_ram import cpu_pkg::*; (
  input  logic              clk,
  mem_bus_if.memory         bus,
  input  logic [ADDR_W-1:0] host_addr,
  input  logic [DATA_W-1:0] host_wdata,
  input  logic              host_we,
  output logic [DATA_W-1:0] host_rdata
);

  // Full 64 KB address space
  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [0:DEPTH-1];

  // ----------------------------------------------------------
  // Writes
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    // Host first
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    // Core last so it wins a same-address clash
    if (bus.wr_en) begin
      mem[bus.addr] <= bus.wr_data;
    end
  end

  // ----------------------------------------------------------
  // Reads
  // ----------------------------------------------------------
  // Core sees the byte in the cycle after it sets addr
  assign bus.rd_data = mem[bus.addr];

  // Host read path
  assign host_rdata = mem[host_addr];

endmodule

// ==== rtl/cpu_system.sv ====
`timescale 1ns/1ps

module cpu_system import cpu_pkg::*; (
  input  logic              clk,
  input  logic              resetn,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // ----------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------
  // Host control and status
  logic              run;
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] status;
  logic              halted;

  // Core to ALU
  alu_op_t           alu_op;
  logic [DATA_W-1:0] alu_a;
  logic [DATA_W-1:0] alu_b;
  logic              alu_cin;
  logic [DATA_W-1:0] alu_y;
  logic [DATA_W-1:0] alu_flags;

  // Host side of the RAM
  logic [ADDR_W-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata;
  logic              ram_we;
  logic [DATA_W-1:0] ram_rdata;

  mem_bus_if mem_bus ();

  apb_host_port host0 (
    .clk(clk), .resetn(resetn),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .run(run), .acc(acc), .status(status), .halted(halted),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
    .ram_rdata(ram_rdata)
  );

  cpu_core core0 (
    .clk(clk), .resetn(resetn), .run(run), .mem(mem_bus.core),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_cin(alu_cin),
    .alu_y(alu_y), .alu_flags(alu_flags),
    .acc(acc), .status(status), .halted(halted)
  );

  cpu_alu alu0 (
    .op(alu_op), .a(alu_a), .b(alu_b), .cin(alu_cin),
    .y(alu_y), .flags(alu_flags)
  );

  cpu_ram ram0 (
    .clk(clk), .bus(mem_bus.memory),
    .host_addr(ram_addr), .host_wdata(ram_wdata), .host_we(ram_we),
    .host_rdata(ram_rdata)
  );

endmodule

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import cpu_pkg::*; ();

  // Address and write data come from core registers
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wr_data;
  logic              wr_en;
  // Combinational read of addr
  logic [DATA_W-1:0] rd_data;

  modport core (
    output addr,
    output wr_data,
    output wr_en,
    input  rd_data
  );

  modport memory (
    input  addr,
    input  wr_data,
    input  wr_en,
    output rd_data
  );

endinterface

// ==== sim/tb_cpu_system.sv ====
`timescale 1ns/1ps

module tb_cpu_system import cpu_pkg::*; ();

  // Run limits
  localparam int          HALT_TIMEOUT = 5000;
  localparam int          MODEL_STEPS  = 1000;
  localparam logic [31:0] SEED         = 32'hd86f_180e;
  // Data window that every program reads and writes
  localparam logic [15:0] DATA_BASE = 16'h2000;
  localparam int unsigned DATA_LEN  = 16;

  logic              clk = 1'b0;
  logic              resetn;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Image as loaded over APB and the model's working copy
  logic [7:0]  img [0:65535];
  logic [7:0]  exp_mem [0:65535];
  logic [15:0] load_q [$];

  // Comparisons waiting for the checker
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       what_q [$];
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  string       chk_what;

  int cycle_count = 0;

  cpu_system dut0 (
    .clk(clk), .resetn(resetn),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    stop_failed();
  endtask

  // ----------------------------------------------------------
  // APB master
  // ----------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata, input logic expect_err,
                          output logic [APB_DW-1:0] rdata);
    logic err;
    // Setup phase
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    // Access phase with pready always high
    @(posedge clk);
    penable <= 1'b1;
    // Sample mid-cycle
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    assert (pready === 1'b1) else report_mismatch("pready low in access phase");
    assert (err === expect_err)
      else report_mismatch($sformatf("pslverr %b at address %h", err, addr));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic [APB_DW-1:0] unused;
    apb_xfer(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
    apb_xfer(1'b0, addr, '0, 1'b0, data);
  endtask

  // Read and hand the pair to the checker
  task automatic check_read(input logic [APB_AW-1:0] addr, input logic [31:0] expected,
                            input string what);
    logic [APB_DW-1:0] data;
    apb_read(addr, data);
    got_q.push_back(data);
    exp_q.push_back(expected);
    what_q.push_back(what);
  endtask

  // Checker
  always @(posedge clk) begin
    while (got_q.size() > 0) begin
      chk_got  = got_q.pop_front();
      chk_exp  = exp_q.pop_front();
      chk_what = what_q.pop_front();
      assert (chk_got === chk_exp)
        else report_mismatch($sformatf("%s got %h expected %h", chk_what, chk_got, chk_exp));
    end
  end

  // ----------------------------------------------------------
  // Program image
  // ----------------------------------------------------------
  function automatic void put_byte(input logic [15:0] at, input logic [7:0] val);
    img[at] = val;
    load_q.push_back(at);
  endfunction

  function automatic void put_instr(input logic [15:0] at, input logic [7:0] op,
                                    input logic [15:0] ea);
    put_byte(at, op);
    put_byte(at + 16'd1, ea[7:0]);
    put_byte(at + 16'd2, ea[15:8]);
  endfunction

  function automatic void fill_data();
    int k;
    for (k = 0; k < DATA_LEN; k++) begin
      put_byte(DATA_BASE + 16'(k), 8'($urandom));
    end
  endfunction

  function automatic logic [7:0] with_nz(input logic [7:0] p, input logic [7:0] v);
    logic [7:0] r;
    r = p;
    r[FLAG_N] = v[7];
    r[FLAG_Z] = (v == 8'h00);
    return r;
  endfunction

  // Instruction-level model on exp_mem
  function automatic void model_run(output logic [7:0] a, output logic [7:0] p,
                                    output logic halted);
    logic [15:0] pc;
    logic [15:0] ea;
    logic [7:0]  op;
    logic [7:0]  m;
    logic [8:0]  sum;
    int          steps;
    a = 8'h00;
    p = 8'h00;
    p[FLAG_UNUSED] = 1'b1;
    halted = 1'b0;
    steps = 0;
    pc = {exp_mem[RESET_VEC_HI], exp_mem[RESET_VEC_LO]};
    while (!halted && steps < MODEL_STEPS) begin
      op = exp_mem[pc];
      ea = {exp_mem[pc + 16'd2], exp_mem[pc + 16'd1]};
      m  = exp_mem[ea];
      case (op)
        NOP:     pc = pc + 16'd1;
        JMP_ABS: pc = ea;
        LDA_ABS: begin
          a = m;
          p = with_nz(p, a);
        end
        AND_ABS: begin
          a = a & m;
          p = with_nz(p, a);
        end
        ADC_ABS: begin
          sum = {1'b0, a} + {1'b0, m} + {8'h00, p[FLAG_C]};
          // Overflow when the result sign differs from both inputs
          p[FLAG_V] = ((a ^ sum[7:0]) & (m ^ sum[7:0]) & 8'h80) != 8'h00;
          p[FLAG_C] = sum[8];
          a = sum[7:0];
          p = with_nz(p, a);
        end
        STA_ABS: exp_mem[ea] = a;
        ASL_ABS: begin
          p[FLAG_C] = m[7];
          m = {m[6:0], 1'b0};
          exp_mem[ea] = m;
          p = with_nz(p, m);
        end
        default: halted = 1'b1;
      endcase
      if (!halted && op != NOP && op != JMP_ABS) begin
        pc = pc + 16'd3;
      end
      steps++;
    end
  endfunction

  // Random straight-line program with forward jumps
  task automatic gen_program(input int n_instr);
    logic [15:0] pc;
    logic [15:0] ea;
    logic [7:0]  op;
    int          i;
    load_q.delete();
    pc = 16'h0300 + 16'($urandom % 64) * 16'd16;
    put_byte(RESET_VEC_LO, pc[7:0]);
    put_byte(RESET_VEC_HI, pc[15:8]);
    fill_data();
    for (i = 0; i < n_instr; i++) begin
      ea = DATA_BASE + 16'($urandom % DATA_LEN);
      case (int'($urandom % 8))
        0:       op = LDA_ABS;
        1, 2:    op = ADC_ABS;
        3:       op = AND_ABS;
        4:       op = STA_ABS;
        5:       op = ASL_ABS;
        6:       op = NOP;
        default: op = JMP_ABS;
      endcase
      if (op == NOP) begin
        put_byte(pc, op);
        pc = pc + 16'd1;
      end else begin
        // Jump target skips a short gap
        if (op == JMP_ABS) ea = pc + 16'd3 + 16'($urandom % 32);
        put_instr(pc, op, ea);
        pc = (op == JMP_ABS) ? ea : pc + 16'd3;
      end
    end
    // Ends on BRK or some unsupported byte
    op = 8'($urandom);
    if (op inside {ADC_ABS, AND_ABS, ASL_ABS, LDA_ABS, STA_ABS, JMP_ABS, NOP}) op = 8'h00;
    put_byte(pc, op);
  endtask

  // ----------------------------------------------------------
  // Run one loaded image against the model
  // ----------------------------------------------------------
  task automatic wait_halted();
    logic [APB_DW-1:0] st;
    int                start;
    st = '0;
    start = cycle_count;
    while (!st[16] && (cycle_count - start) < HALT_TIMEOUT) begin
      apb_read(APB_STAT_ADDR, st);
    end
    if (!st[16]) begin
      $display("Core never halted within %0d cycles", HALT_TIMEOUT);
      stop_failed();
    end
  endtask

  task automatic run_and_check(input string name);
    logic [7:0] m_a;
    logic [7:0] m_p;
    logic       m_halt;
    int         k;
    // Load while the core is stopped
    apb_write(APB_CTRL_ADDR, 32'h0);
    foreach (load_q[i]) apb_write({1'b0, load_q[i]}, {24'h0, img[load_q[i]]});
    exp_mem = img;
    model_run(m_a, m_p, m_halt);
    apb_write(APB_CTRL_ADDR, 32'h1);
    wait_halted();
    for (k = 0; k < DATA_LEN; k++) begin
      check_read({1'b0, DATA_BASE + 16'(k)}, {24'h0, exp_mem[DATA_BASE + 16'(k)]},
                 $sformatf("%s RAM %h", name, DATA_BASE + 16'(k)));
    end
    check_read(APB_STAT_ADDR, {15'h0, m_halt, m_a, m_p}, {name, " STAT"});
  endtask

  // ----------------------------------------------------------
  // Directed cases
  // ----------------------------------------------------------
  task automatic apb_error_case();
    logic [APB_DW-1:0] rd;
    apb_xfer(1'b1, APB_STAT_ADDR, 32'h1, 1'b1, rd);
    apb_xfer(1'b0, 17'h1_0008, 32'h0, 1'b1, rd);
    apb_xfer(1'b1, 17'h1_FFFC, 32'h0, 1'b1, rd);
    // Upper data bits dropped and read back zero-extended
    apb_write(17'h0_1234, 32'hDEAD_BEA5);
    check_read(17'h0_1234, 32'h0000_00A5, "RAM write then read");
  endtask

  task automatic jmp_chain_case();
    load_q.delete();
    put_byte(RESET_VEC_LO, 8'h00);
    put_byte(RESET_VEC_HI, 8'h04);
    fill_data();
    put_byte(DATA_BASE, 8'h5A);
    put_instr(16'h0400, LDA_ABS, DATA_BASE);
    put_instr(16'h0403, JMP_ABS, 16'h0480);
    put_instr(16'h0480, JMP_ABS, 16'h0500);
    put_instr(16'h0500, STA_ABS, DATA_BASE + 16'd1);
    put_byte(16'h0503, 8'h00);
    run_and_check("jmp chain");
    check_read({1'b0, DATA_BASE + 16'd1}, 32'h5A, "STA after jmp chain");
  endtask

  task automatic asl_case();
    load_q.delete();
    put_byte(RESET_VEC_LO, 8'h00);
    put_byte(RESET_VEC_HI, 8'h06);
    fill_data();
    put_byte(DATA_BASE, 8'hC1);
    put_instr(16'h0600, ASL_ABS, DATA_BASE);
    put_byte(16'h0603, 8'h00);
    run_and_check("asl");
    check_read({1'b0, DATA_BASE}, 32'h82, "ASL result in memory");
    // N and C set with A untouched
    check_read(APB_STAT_ADDR, 32'h0001_00A1, "ASL flags");
  endtask

  task automatic nop_halt_case();
    load_q.delete();
    put_byte(RESET_VEC_LO, 8'h00);
    put_byte(RESET_VEC_HI, 8'h07);
    fill_data();
    put_byte(DATA_BASE + 16'd2, 8'h80);
    put_instr(16'h0700, LDA_ABS, DATA_BASE + 16'd2);
    put_byte(16'h0703, NOP);
    put_byte(16'h0704, NOP);
    put_instr(16'h0705, STA_ABS, DATA_BASE + 16'd3);
    put_byte(16'h0708, 8'hFF);
    run_and_check("nop");
    // Halt holds until run drops
    check_read(APB_STAT_ADDR, 32'h0001_80A0, "STAT while halted");
    check_read(APB_STAT_ADDR, 32'h0001_80A0, "STAT still halted");
    check_read(APB_CTRL_ADDR, 32'h0000_0001, "CTRL while halted");
    apb_write(APB_CTRL_ADDR, 32'h0);
    check_read(APB_CTRL_ADDR, 32'h0000_0000, "CTRL after run cleared");
    check_read(APB_STAT_ADDR, 32'h0000_0020, "STAT after run cleared");
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int prog;
    void'($urandom(SEED));
    resetn  <= 1'b0;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    repeat (5) @(posedge clk);
    resetn <= 1'b1;

    apb_error_case();
    jmp_chain_case();
    asl_case();
    nop_halt_case();
    // Each restart runs a fresh program from the vector
    for (prog = 0; prog < 4; prog++) begin
      gen_program(24);
      run_and_check($sformatf("random program %0d", prog));
    end

    // Let the checker drain
    repeat (2) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule
